// File: all.f
+incdir+verif
rtl/lock_pkg.sv
rtl/ms_tick.sv
rtl/button_debounce.sv
rtl/code_matcher.sv
rtl/lock_config.sv
rtl/door_fsm.sv
rtl/door_lock_top.sv
verif/door_lock_tb.sv

// File: rtl/button_debounce.sv
module button_debounce (
    input  logic clk,
    input  logic rst,
    input  logic tick,
    input  logic button,
    output logic press
);

    lock_pkg::ms_t stable_ms;   // Ticks the button has stayed high
    logic          armed;       // Cleared after a press until release
    logic          stable_done;

    assign stable_done = (stable_ms == lock_pkg::ms_t'(lock_pkg::DEBOUNCE_MS - 1));

    // Fires on the tick that completes the stable window
    assign press = tick && button && armed && stable_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stable_ms <= '0;
            armed     <= 1'b1;
        end else if (tick) begin
            if (!button) begin
                stable_ms <= '0;                    // Release restarts and re-arms
                armed     <= 1'b1;
            end else if (armed) begin
                if (stable_done) begin
                    stable_ms <= '0;
                    armed     <= 1'b0;
                end else begin
                    stable_ms <= stable_ms + 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/code_matcher.sv
module code_matcher (
    input  logic            clk,
    input  logic            rst,
    input  logic            check_start,
    input  lock_pkg::code_t check_code,
    input  lock_pkg::code_t code0,
    input  lock_pkg::code_t code1,
    input  lock_pkg::code_t code2,
    input  lock_pkg::code_t code3,
    output logic            check_done,
    output logic            check_match
);

    lock_pkg::slot_t slot;
    logic            busy;
    lock_pkg::code_t slot_code;
    logic            hit;
    logic            last_slot;

    // One stored code per cycle
    always_comb begin
        case (slot)
            2'd0:    slot_code = code0;
            2'd1:    slot_code = code1;
            2'd2:    slot_code = code2;
            default: slot_code = code3;
        endcase
    end

    assign hit         = (slot_code != lock_pkg::CODE_EMPTY) && (slot_code == check_code);
    assign last_slot   = (slot == lock_pkg::slot_t'(lock_pkg::NUM_SLOTS - 1));
    assign check_done  = busy && (hit || last_slot);    // Early exit on a match
    assign check_match = busy && hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            slot <= '0;
        end else if (check_start) begin
            busy <= 1'b1;
            slot <= '0;
        end else if (busy) begin
            if (check_done) begin
                busy <= 1'b0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

endmodule

// File: rtl/door_fsm.sv
module door_fsm (
    input  logic            clk,
    input  logic            rst,
    input  logic            tick,
    input  logic            press,
    input  logic            door_open,
    input  lock_pkg::code_t key_code,
    input  logic            key_valid,
    input  logic            cfg_load,
    input  logic            check_done,
    input  logic            check_match,
    input  logic            beep_en,
    input  lock_pkg::sec_t  beep_s,
    input  lock_pkg::sec_t  autolock_s,
    output logic            check_start,
    output lock_pkg::code_t check_code,
    output logic            cfg_we,
    output logic            bolt,
    output logic            beep,
    output lock_pkg::bcd_t  bcd
);

    lock_pkg::door_state_t state;
    lock_pkg::door_state_t state_next;
    lock_pkg::attempts_t   attempts;
    lock_pkg::ms_t         timer;       // Shared by UNLATCHED, OPEN and LOCKOUT
    lock_pkg::ms_t         autolock_ms;
    lock_pkg::ms_t         beep_ms;
    lock_pkg::digit_t      key_digit0;
    logic                  key_timeout;
    logic                  key_check;   // Entry that goes to the matcher
    logic                  start_check;

    assign key_digit0  = key_code[3:0];
    assign key_timeout = key_valid && (key_digit0 == lock_pkg::DIGIT_TIMEOUT);
    assign key_check   = key_valid && !key_timeout && (key_digit0 != lock_pkg::DIGIT_CANCEL);

    assign autolock_ms = lock_pkg::ms_t'(autolock_s) * lock_pkg::ms_t'(lock_pkg::MS_PER_S);
    assign beep_ms     = lock_pkg::ms_t'(beep_s) * lock_pkg::ms_t'(lock_pkg::MS_PER_S);

    always_comb begin
        state_next = state;
        case (state)
            lock_pkg::INIT: begin
                if (!door_open) state_next = lock_pkg::LOCKED;
            end
            lock_pkg::LOCKED: begin
                if (press) begin
                    state_next = lock_pkg::UNLATCHED;
                end else if (key_timeout) begin
                    if (beep_en) state_next = lock_pkg::TIMEOUT_BEEP;
                end else if (key_check) begin
                    state_next = lock_pkg::CHECKING;
                end
            end
            lock_pkg::CHECKING: begin
                if (check_done) begin
                    state_next = check_match ? lock_pkg::UNLATCHED : lock_pkg::WRONG;
                end
            end
            lock_pkg::WRONG: begin
                if (attempts == lock_pkg::attempts_t'(lock_pkg::MAX_ATTEMPTS - 1)) begin
                    state_next = lock_pkg::LOCKOUT;     // This miss is the last allowed
                end else begin
                    state_next = lock_pkg::LOCKED;
                end
            end
            lock_pkg::LOCKOUT: begin
                if (timer >= lock_pkg::ms_t'(lock_pkg::LOCKOUT_MS)) state_next = lock_pkg::LOCKED;
            end
            lock_pkg::UNLATCHED: begin
                if (door_open) begin
                    state_next = lock_pkg::OPEN;
                end else if (press || timer >= autolock_ms) begin
                    state_next = lock_pkg::LOCKED;
                end
            end
            lock_pkg::OPEN: begin
                if (!door_open) begin
                    state_next = lock_pkg::UNLATCHED;
                end else if (beep_en && timer >= beep_ms) begin
                    state_next = lock_pkg::OPEN_ALARM;
                end
            end
            lock_pkg::OPEN_ALARM: begin
                if (!door_open) state_next = lock_pkg::UNLATCHED;
            end
            lock_pkg::TIMEOUT_BEEP: state_next = lock_pkg::LOCKED;   // Single beep cycle
            default:                state_next = lock_pkg::INIT;
        endcase
    end

    assign start_check = (state == lock_pkg::LOCKED) && (state_next == lock_pkg::CHECKING);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= lock_pkg::INIT;
            attempts    <= '0;
            timer       <= '0;
            check_start <= 1'b0;
        end else begin
            state       <= state_next;
            check_start <= start_check;
            // Timer restarts on every state change and saturates
            if (state_next != state) begin
                timer <= '0;
            end else if (tick && timer != '1) begin
                timer <= timer + 1'b1;
            end
            if (state == lock_pkg::WRONG) begin
                attempts <= attempts + 1'b1;
            end else if ((state == lock_pkg::CHECKING && check_done && check_match)
                         || (state == lock_pkg::LOCKOUT && state_next == lock_pkg::LOCKED)) begin
                attempts <= '0;
            end
        end
    end

    // Entered code held for the matcher during CHECKING
    always_ff @(posedge clk) begin
        if (start_check) check_code <= key_code;
    end

    assign cfg_we = (state == lock_pkg::OPEN) && cfg_load;   // Setup only with the door open

    assign bolt = state inside {lock_pkg::LOCKED, lock_pkg::CHECKING, lock_pkg::WRONG,
                                lock_pkg::LOCKOUT, lock_pkg::TIMEOUT_BEEP};
    assign beep = state inside {lock_pkg::OPEN_ALARM, lock_pkg::TIMEOUT_BEEP};

    // One mark per wrong attempt from digit 0 upward
    always_comb begin
        for (int i = 0; i < $bits(lock_pkg::bcd_t) / $bits(lock_pkg::digit_t); i++) begin
            if (state == lock_pkg::LOCKOUT || int'(attempts) > i) begin
                bcd[i*4 +: 4] = lock_pkg::DIGIT_MARK;
            end else begin
                bcd[i*4 +: 4] = lock_pkg::DIGIT_BLANK;
            end
        end
    end

endmodule

// File: rtl/door_lock_top.sv
module door_lock_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            door_open,
    input  logic            inside_button,
    input  lock_pkg::code_t key_code,
    input  logic            key_valid,
    input  logic            cfg_load,
    input  lock_pkg::code_t cfg_code0,
    input  lock_pkg::code_t cfg_code1,
    input  lock_pkg::code_t cfg_code2,
    input  lock_pkg::code_t cfg_code3,
    input  logic            cfg_beep_en,
    input  lock_pkg::sec_t  cfg_beep_s,
    input  lock_pkg::sec_t  cfg_autolock_s,
    output logic            bolt,
    output logic            beep,
    output lock_pkg::bcd_t  bcd
);

    logic            tick;
    logic            press;
    logic            check_start;
    logic            check_done;
    logic            check_match;
    lock_pkg::code_t check_code;
    logic            cfg_we;
    lock_pkg::code_t code0;
    lock_pkg::code_t code1;
    lock_pkg::code_t code2;
    lock_pkg::code_t code3;
    logic            beep_en;
    lock_pkg::sec_t  beep_s;
    lock_pkg::sec_t  autolock_s;

    ms_tick tick0 (.clk(clk), .rst(rst), .tick(tick));

    button_debounce button0 (
        .clk(clk), .rst(rst), .tick(tick), .button(inside_button), .press(press)
    );

    code_matcher matcher0 (
        .clk(clk), .rst(rst), .check_start(check_start), .check_code(check_code),
        .code0(code0), .code1(code1), .code2(code2), .code3(code3),
        .check_done(check_done), .check_match(check_match)
    );

    lock_config config0 (
        .clk(clk), .rst(rst), .cfg_we(cfg_we),
        .cfg_code0(cfg_code0), .cfg_code1(cfg_code1), .cfg_code2(cfg_code2),
        .cfg_code3(cfg_code3), .cfg_beep_en(cfg_beep_en), .cfg_beep_s(cfg_beep_s),
        .cfg_autolock_s(cfg_autolock_s),
        .code0(code0), .code1(code1), .code2(code2), .code3(code3),
        .beep_en(beep_en), .beep_s(beep_s), .autolock_s(autolock_s)
    );

    door_fsm fsm0 (
        .clk(clk), .rst(rst), .tick(tick), .press(press), .door_open(door_open),
        .key_code(key_code), .key_valid(key_valid), .cfg_load(cfg_load),
        .check_done(check_done), .check_match(check_match),
        .beep_en(beep_en), .beep_s(beep_s), .autolock_s(autolock_s),
        .check_start(check_start), .check_code(check_code), .cfg_we(cfg_we),
        .bolt(bolt), .beep(beep), .bcd(bcd)
    );

endmodule

// File: rtl/lock_config.sv
module lock_config (
    input  logic            clk,
    input  logic            rst,
    input  logic            cfg_we,
    input  lock_pkg::code_t cfg_code0,
    input  lock_pkg::code_t cfg_code1,
    input  lock_pkg::code_t cfg_code2,
    input  lock_pkg::code_t cfg_code3,
    input  logic            cfg_beep_en,
    input  lock_pkg::sec_t  cfg_beep_s,
    input  lock_pkg::sec_t  cfg_autolock_s,
    output lock_pkg::code_t code0,
    output lock_pkg::code_t code1,
    output lock_pkg::code_t code2,
    output lock_pkg::code_t code3,
    output logic            beep_en,
    output lock_pkg::sec_t  beep_s,
    output lock_pkg::sec_t  autolock_s
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Factory state has a single usable code
            code0      <= lock_pkg::DEFAULT_CODE;
            code1      <= lock_pkg::CODE_EMPTY;
            code2      <= lock_pkg::CODE_EMPTY;
            code3      <= lock_pkg::CODE_EMPTY;
            beep_en    <= 1'b1;
            beep_s     <= lock_pkg::DEFAULT_SEC;
            autolock_s <= lock_pkg::DEFAULT_SEC;
        end else if (cfg_we) begin
            code0      <= cfg_code0;
            code1      <= cfg_code1;
            code2      <= cfg_code2;
            code3      <= cfg_code3;
            beep_en    <= cfg_beep_en;
            beep_s     <= cfg_beep_s;
            autolock_s <= cfg_autolock_s;
        end
    end

endmodule

// File: rtl/lock_pkg.sv
package lock_pkg;

    // Widths with a meaning of their own
    typedef logic [15:0] code_t;        // Four BCD digits from the keypad
    typedef logic [3:0]  digit_t;
    typedef logic [23:0] bcd_t;         // Six display digits with digit 0 in the low nibble
    typedef logic [3:0]  sec_t;
    typedef logic [14:0] ms_t;
    typedef logic [2:0]  attempts_t;
    typedef logic [1:0]  slot_t;

    // Door controller states
    typedef enum logic [3:0] {
        INIT,
        LOCKED,
        CHECKING,       // Waiting on the code matcher
        WRONG,
        LOCKOUT,
        UNLATCHED,
        OPEN,
        OPEN_ALARM,
        TIMEOUT_BEEP
    } door_state_t;

    // Small tick count keeps simulation short
    localparam int TICKS_PER_MS = 4;
    localparam int DEBOUNCE_MS  = 100;
    localparam int LOCKOUT_MS   = 30000;
    localparam int MS_PER_S     = 1000;

    localparam int MAX_ATTEMPTS = 5;
    localparam int NUM_SLOTS    = 4;

    // Keypad markers in digit 0
    localparam digit_t DIGIT_TIMEOUT = 4'hE;
    localparam digit_t DIGIT_CANCEL  = 4'hB;

    // Display digits
    localparam digit_t DIGIT_MARK  = 4'hA;
    localparam digit_t DIGIT_BLANK = 4'hB;

    localparam code_t CODE_EMPTY   = 16'hFFFF;  // Unused slot that never matches
    localparam code_t DEFAULT_CODE = 16'h1234;
    localparam sec_t  DEFAULT_SEC  = 4'd5;

endpackage

// File: rtl/ms_tick.sv
module ms_tick (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [$clog2(lock_pkg::TICKS_PER_MS)-1:0] cnt;
    logic                                      wrap;

    assign wrap = (cnt == ($clog2(lock_pkg::TICKS_PER_MS))'(lock_pkg::TICKS_PER_MS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= wrap;                           // One cycle per wrap
            if (wrap) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log &&
verilator --binary --timing --top-module door_lock_tb -f all.f -o door_lock_sim &&
./obj_dir/door_lock_sim > sim.log 2>&1
grep -qF "** PASS **" sim.log && echo "simulation passed" ||
{ cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }

// File: verif/lock_model.svh
`ifndef LOCK_MODEL_SVH
`define LOCK_MODEL_SVH

// Door rules stepped once per clock from the testbench inputs
lock_pkg::door_state_t m_state;
int                    m_count;         // Wrong codes since the last clear
int                    m_timer;         // Milliseconds spent in the current state
int                    m_pre;           // Cycle prescaler for the millisecond tick
bit                    m_tick;
int                    m_high_ms;       // Ticks with the button held high
bit                    m_armed;
int                    m_wait;          // Cycles left before the match result
bit                    m_match;
lock_pkg::code_t       m_code [4];
bit                    m_beep_en;
int                    m_beep_s;
int                    m_autolock_s;

task automatic reset_model();
    m_state      = lock_pkg::INIT;
    m_count      = 0;
    m_timer      = 0;
    m_pre        = 0;
    m_tick       = 1'b0;
    m_high_ms    = 0;
    m_armed      = 1'b1;
    m_wait       = 0;
    m_match      = 1'b0;
    m_code[0]    = lock_pkg::DEFAULT_CODE;
    m_code[1]    = lock_pkg::CODE_EMPTY;
    m_code[2]    = lock_pkg::CODE_EMPTY;
    m_code[3]    = lock_pkg::CODE_EMPTY;
    m_beep_en    = 1'b1;
    m_beep_s     = int'(lock_pkg::DEFAULT_SEC);
    m_autolock_s = int'(lock_pkg::DEFAULT_SEC);
endtask

task automatic step_model();
    lock_pkg::door_state_t nxt;
    bit                    tick_now;
    bit                    press;
    tick_now = m_tick;
    m_tick   = (m_pre == lock_pkg::TICKS_PER_MS - 1);
    m_pre    = m_tick ? 0 : m_pre + 1;
    press    = 1'b0;
    if (tick_now) begin
        if (!inside_button) begin
            m_high_ms = 0;
            m_armed   = 1'b1;
        end else if (m_armed) begin
            m_high_ms++;
            if (m_high_ms == lock_pkg::DEBOUNCE_MS) begin
                press     = 1'b1;                 // One press per stable hold
                m_armed   = 1'b0;
                m_high_ms = 0;
            end
        end
    end
    nxt = m_state;
    case (m_state)
        lock_pkg::INIT: if (!door_open) nxt = lock_pkg::LOCKED;
        lock_pkg::LOCKED: begin
            if (press) begin
                nxt = lock_pkg::UNLATCHED;
            end else if (key_valid && key_code[3:0] == lock_pkg::DIGIT_TIMEOUT) begin
                if (m_beep_en) nxt = lock_pkg::TIMEOUT_BEEP;
            end else if (key_valid && key_code[3:0] != lock_pkg::DIGIT_CANCEL) begin
                nxt     = lock_pkg::CHECKING;
                m_match = 1'b0;
                m_wait  = lock_pkg::NUM_SLOTS + 1;
                for (int k = 0; k < lock_pkg::NUM_SLOTS; k++) begin
                    if (!m_match && m_code[k] != lock_pkg::CODE_EMPTY
                        && m_code[k] == key_code) begin
                        m_match = 1'b1;
                        m_wait  = k + 2;      // Start pulse plus one slot per cycle
                    end
                end
            end
        end
        lock_pkg::CHECKING: begin
            m_wait--;
            if (m_wait == 0) begin
                nxt = m_match ? lock_pkg::UNLATCHED : lock_pkg::WRONG;
                if (m_match) m_count = 0;
            end
        end
        lock_pkg::WRONG: begin
            m_count++;
            nxt = (m_count >= lock_pkg::MAX_ATTEMPTS) ? lock_pkg::LOCKOUT : lock_pkg::LOCKED;
        end
        lock_pkg::LOCKOUT: begin
            if (m_timer >= lock_pkg::LOCKOUT_MS) begin
                nxt     = lock_pkg::LOCKED;
                m_count = 0;
            end
        end
        lock_pkg::UNLATCHED: begin
            if (door_open) begin
                nxt = lock_pkg::OPEN;
            end else if (press || m_timer >= m_autolock_s * lock_pkg::MS_PER_S) begin
                nxt = lock_pkg::LOCKED;
            end
        end
        lock_pkg::OPEN: begin
            if (!door_open) begin
                nxt = lock_pkg::UNLATCHED;
            end else if (m_beep_en && m_timer >= m_beep_s * lock_pkg::MS_PER_S) begin
                nxt = lock_pkg::OPEN_ALARM;
            end
            if (cfg_load) begin
                m_code[0]    = cfg_code0;
                m_code[1]    = cfg_code1;
                m_code[2]    = cfg_code2;
                m_code[3]    = cfg_code3;
                m_beep_en    = cfg_beep_en;
                m_beep_s     = int'(cfg_beep_s);
                m_autolock_s = int'(cfg_autolock_s);
            end
        end
        lock_pkg::OPEN_ALARM:   if (!door_open) nxt = lock_pkg::UNLATCHED;
        default:                nxt = lock_pkg::LOCKED;
    endcase
    if (nxt != m_state) m_timer = 0;
    else if (tick_now && m_timer < 32767) m_timer++;
    m_state = nxt;
endtask

function automatic bit bolt_thrown();
    return m_state inside {lock_pkg::LOCKED, lock_pkg::CHECKING, lock_pkg::WRONG,
                           lock_pkg::LOCKOUT, lock_pkg::TIMEOUT_BEEP};
endfunction

function automatic bit beep_on();
    return m_state inside {lock_pkg::OPEN_ALARM, lock_pkg::TIMEOUT_BEEP};
endfunction

function automatic lock_pkg::bcd_t mark_display();
    lock_pkg::bcd_t v;
    for (int i = 0; i < 6; i++) begin
        v[i*4 +: 4] = (m_state == lock_pkg::LOCKOUT || m_count > i) ? lock_pkg::DIGIT_MARK
                                                                     : lock_pkg::DIGIT_BLANK;
    end
    return v;
endfunction

`endif

// File: verif/door_lock_tb.sv
module door_lock_tb;

    localparam int     NUM_RANDOM     = 24;
    localparam int     EVENT_BUDGET   = NUM_RANDOM * 3 + 60;
    localparam longint LONGEST_CYCLES = longint'(lock_pkg::LOCKOUT_MS) * lock_pkg::TICKS_PER_MS;
    localparam longint WATCHDOG_TIME  = longint'(EVENT_BUDGET) * (LONGEST_CYCLES + 2000) * 10;

    logic            clk;
    logic            rst;
    logic            door_open;
    logic            inside_button;
    lock_pkg::code_t key_code;
    logic            key_valid;
    logic            cfg_load;
    lock_pkg::code_t cfg_code0;
    lock_pkg::code_t cfg_code1;
    lock_pkg::code_t cfg_code2;
    lock_pkg::code_t cfg_code3;
    logic            cfg_beep_en;
    lock_pkg::sec_t  cfg_beep_s;
    lock_pkg::sec_t  cfg_autolock_s;
    logic            bolt;
    logic            beep;
    lock_pkg::bcd_t  bcd;
    bit [31:0]       lfsr = 32'h42ca_dd03;

    `include "lock_model.svh"

    door_lock_top dut0 (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (rst) reset_model();
        else step_model();
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired, the run did not finish in time");
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    function automatic bit [31:0] lfsr_next(input bit [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic bit [31:0] draw_bits(input int n);
        bit [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic lock_pkg::code_t draw_code();
        bit [31:0] pick;
        pick = draw_bits(2);
        if (pick < 2) return m_code[draw_bits(2)];     // Stored code that may be empty
        if (pick == 2) return lock_pkg::code_t'(draw_bits(16));
        return lock_pkg::CODE_EMPTY;
    endfunction

    function automatic lock_pkg::code_t draw_wrong_code();
        lock_pkg::code_t c;
        bit              bad;
        bad = 1'b1;
        while (bad) begin
            c   = lock_pkg::code_t'(draw_bits(16));
            bad = (c[3:0] == lock_pkg::DIGIT_TIMEOUT) || (c[3:0] == lock_pkg::DIGIT_CANCEL);
            for (int k = 0; k < 4; k++) if (c == m_code[k]) bad = 1'b1;
        end
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "first error");
        end
    endtask

    task automatic check_outputs();
        check_value("bolt", 32'(bolt), 32'(bolt_thrown()));
        check_value("beep", 32'(beep), 32'(beep_on()));
        check_value("bcd", 32'(bcd), 32'(mark_display()));
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic settle_and_check();
        wait_cycles(8);
        check_outputs();
    endtask

    task automatic wait_ms(input int ms);
        wait_cycles(ms * lock_pkg::TICKS_PER_MS);
        check_outputs();
    endtask

    // Beep cycles are counted so a one-cycle beep is seen
    task automatic enter_code(input lock_pkg::code_t code);
        int dut_beeps;
        int model_beeps;
        dut_beeps   = 0;
        model_beeps = 0;
        key_code    = code;
        key_valid   = 1'b1;
        for (int i = 0; i < 8; i++) begin
            wait_cycles(1);
            key_valid = 1'b0;
            if (beep) dut_beeps++;
            if (beep_on()) model_beeps++;
        end
        check_value("beep cycles", 32'(dut_beeps), 32'(model_beeps));
        check_outputs();
    endtask

    task automatic hold_button(input int ms);
        inside_button = 1'b1;
        wait_cycles(ms * lock_pkg::TICKS_PER_MS);
        inside_button = 1'b0;
        settle_and_check();
    endtask

    task automatic set_door(input logic v);
        door_open = v;
        settle_and_check();
    endtask

    task automatic load_config(input lock_pkg::code_t c0, input lock_pkg::code_t c1,
                               input lock_pkg::code_t c2, input lock_pkg::code_t c3,
                               input bit ben, input int bs, input int as);
        cfg_code0      = c0;
        cfg_code1      = c1;
        cfg_code2      = c2;
        cfg_code3      = c3;
        cfg_beep_en    = ben;
        cfg_beep_s     = lock_pkg::sec_t'(bs);
        cfg_autolock_s = lock_pkg::sec_t'(as);
        cfg_load       = 1'b1;
        wait_cycles(1);
        cfg_load = 1'b0;
        settle_and_check();
    endtask

    task automatic return_to_locked();
        while (m_state != lock_pkg::LOCKED) begin
            if (m_state == lock_pkg::UNLATCHED) hold_button(120);
            else wait_cycles(1);
        end
        settle_and_check();
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        door_open      = 1'b0;
        inside_button  = 1'b0;
        key_code       = '0;
        key_valid      = 1'b0;
        cfg_load       = 1'b0;
        cfg_code0      = '0;
        cfg_code1      = '0;
        cfg_code2      = '0;
        cfg_code3      = '0;
        cfg_beep_en    = 1'b0;
        cfg_beep_s     = '0;
        cfg_autolock_s = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        settle_and_check();                         // Locked with a blank display

        hold_button(50);                            // Too short to unlatch
        hold_button(120);
        hold_button(120);

        hold_button(120);
        wait_ms(5200);                              // Auto-lock at the default time
        hold_button(120);
        set_door(1'b1);
        wait_ms(5200);                              // Door held open too long
        set_door(1'b0);

        load_config(16'h1111, 16'h2222, 16'h3333, 16'h4444, 1'b0, 1, 1);  // Door closed
        wait_ms(1100);                              // Default auto-lock time still applies
        set_door(1'b1);
        load_config(lock_pkg::code_t'(draw_bits(16)), lock_pkg::code_t'(draw_bits(16)),
                    lock_pkg::code_t'(draw_bits(16)), lock_pkg::CODE_EMPTY, 1'b1, 2, 1);
        set_door(1'b0);
        wait_ms(1100);
        enter_code(16'h000E);                       // Keypad timeout beeps once
        enter_code(16'h123B);                       // Cancel is ignored

        for (int i = 0; i < NUM_RANDOM; i++) begin
            return_to_locked();
            enter_code(draw_code());
        end

        return_to_locked();
        while (m_state != lock_pkg::LOCKOUT) enter_code(draw_wrong_code());
        enter_code(m_code[0]);                      // Ignored during lockout
        wait_ms(lock_pkg::LOCKOUT_MS - 20);         // Still locked out near the end
        while (m_state != lock_pkg::LOCKED) wait_cycles(1);
        settle_and_check();

        hold_button(120);
        set_door(1'b1);
        load_config(m_code[0], m_code[1], m_code[2], m_code[3], 1'b0, 1, 1);
        wait_ms(2000);                              // No alarm with beeping off
        set_door(1'b0);
        return_to_locked();
        enter_code(16'h000E);

        $display("** PASS **");
        $finish;
    end

endmodule
